//--- design/irq_defs.svh
/* Widths and constants of the machine-mode interrupt path.
   Only lines 31..16, 11, 7 and 3 are implemented; other mie/mip bits read 0. */

`ifndef IRQ_DEFS_SVH
`define IRQ_DEFS_SVH

// CSR data and address widths
`define XLEN        32
`define CSR_ADDR_W  12

// Interrupt number width, 32 lines
`define IRQ_ID_W    5

// Implemented lines: 31..16 platform, 11 external, 7 timer, 3 software
`define IRQ_LEGAL_MASK  32'hFFFF_0888

// Field positions in mcause and mstatus
`define MCAUSE_IRQ_BIT    31
`define MSTATUS_MIE_BIT   3
`define MSTATUS_MPIE_BIT  7

`endif

//--- design/irq_pkg.sv
/* Types shared by the interrupt path. Machine mode only, no other CSR
   than the four listed in the address enum is implemented. */

`default_nettype none

`include "irq_defs.svh"

package irq_pkg;

  // Implemented CSR addresses
  typedef enum logic [`CSR_ADDR_W-1:0] {
    MSTATUS = 12'h300,
    MIE     = 12'h304,
    MCAUSE  = 12'h342,
    MIP     = 12'h344
  } csr_addr_e;

  // Stored part of mstatus
  // mpie lives at bit 7, mie at bit 3 of the full register
  typedef struct packed {
    logic mpie;
    logic mie;
  } mstatus_t;

  // Interrupt number
  typedef logic [`IRQ_ID_W-1:0] irq_id_t;

endpackage

`default_nettype wire

//--- design/irq_csr_if.sv
/* Links the CSR block with the arbiter and the trap controller.
   Every signal has exactly one driving modport. */

`timescale 1ns/1ns
`default_nettype none

`include "irq_defs.svh"

interface irq_csr_if;

  // From the CSR block
  logic [`XLEN-1:0]  mie_en;
  logic              m_ie;

  // Registered pending lines from the arbiter
  logic [`XLEN-1:0]  mip;

  // Trap entry request from the trap controller
  logic              take;
  irq_pkg::irq_id_t  take_id;

  modport regs (output mie_en, output m_ie, input mip, input take, input take_id);

  modport arb  (output mip, input mie_en);

  modport trap (output take, output take_id, input m_ie);

endinterface

`default_nettype wire

//--- design/irq_csr_regs.sv
/* Machine CSRs mstatus, mie, mcause and the read view of mip.
   Same-cycle priority: trap entry, then mret, then software write. */

`timescale 1ns/1ns
`default_nettype none

`include "irq_defs.svh"

module irq_csr_regs (
  input  wire logic                    clk_i,
  input  wire logic                    rst_n_i,
  input  wire logic                    csr_we_i,
  input  wire logic [`CSR_ADDR_W-1:0]  csr_addr_i,
  input  wire logic [`XLEN-1:0]        csr_wdata_i,
  output logic      [`XLEN-1:0]        csr_rdata_o,
  input  wire logic                    mret_i,
  irq_csr_if.regs                      csr
);

  irq_pkg::mstatus_t  mstatus_q, mstatus_d;
  logic [`XLEN-1:0]   mie_q, mie_d;
  logic [`XLEN-1:0]   mcause_q, mcause_d;
  logic [`XLEN-1:0]   mcause_take;
  logic [`XLEN-1:0]   mstatus_full;

  ////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////

  // Full 32-bit mstatus view, everything but MIE/MPIE reads 0
  always_comb begin
    mstatus_full                          = '0;
    mstatus_full[`MSTATUS_MIE_BIT]        = mstatus_q.mie;
    mstatus_full[`MSTATUS_MPIE_BIT]       = mstatus_q.mpie;
  end

  // Address decode, unknown CSRs read 0
  always_comb begin
    case (csr_addr_i)
      irq_pkg::MSTATUS: csr_rdata_o = mstatus_full;
      irq_pkg::MIE:     csr_rdata_o = mie_q;
      irq_pkg::MCAUSE:  csr_rdata_o = mcause_q;
      irq_pkg::MIP:     csr_rdata_o = csr.mip;
      default:          csr_rdata_o = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  // Cause on trap entry: interrupt flag plus line number
  always_comb begin
    mcause_take                        = '0;
    mcause_take[`MCAUSE_IRQ_BIT]       = 1'b1;
    mcause_take[`IRQ_ID_W-1:0]         = csr.take_id;
  end

  // Lowest priority first, later assignments override
  always_comb begin
    mstatus_d = mstatus_q;
    mie_d     = mie_q;
    mcause_d  = mcause_q;

    // Software writes
    if (csr_we_i) begin
      case (csr_addr_i)
        irq_pkg::MSTATUS: begin
          mstatus_d.mie  = csr_wdata_i[`MSTATUS_MIE_BIT];
          mstatus_d.mpie = csr_wdata_i[`MSTATUS_MPIE_BIT];
        end
        irq_pkg::MIE:     mie_d    = csr_wdata_i & `IRQ_LEGAL_MASK;
        irq_pkg::MCAUSE:  mcause_d = csr_wdata_i;
        // mip is read only, others not implemented
        default: ;
      endcase
    end

    // Return from trap
    if (mret_i) begin
      mstatus_d.mie  = mstatus_q.mpie;
      mstatus_d.mpie = 1'b1;
    end

    // Trap entry stacks MIE and records the cause
    if (csr.take) begin
      mstatus_d.mpie = mstatus_q.mie;
      mstatus_d.mie  = 1'b0;
      mcause_d       = mcause_take;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mstatus_q <= '0;
      mie_q     <= '0;
      mcause_q  <= '0;
    end else begin
      mstatus_q <= mstatus_d;
      mie_q     <= mie_d;
      mcause_q  <= mcause_d;
    end
  end

  // Enables towards arbiter and trap controller
  assign csr.mie_en = mie_q;
  assign csr.m_ie   = mstatus_q.mie;

  // Unimplemented enable bits stay zero
  a_mie_legal : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (mie_q & ~`IRQ_LEGAL_MASK) == '0
  );

endmodule

`default_nettype wire

//--- design/irq_arbiter.sv
/* Samples irq_i into mip once per cycle, so mip lags irq_i by one clock.
   Selection is combinational: lines 31..16 highest first, then 11, 3, 7. */

`timescale 1ns/1ns
`default_nettype none

`include "irq_defs.svh"

module irq_arbiter (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  input  wire logic [`XLEN-1:0]  irq_i,
  irq_csr_if.arb                 csr,
  output logic                   pending_o,
  output irq_pkg::irq_id_t       sel_id_o
);

  logic [`XLEN-1:0]  mip_q;
  logic [`XLEN-1:0]  enabled;

  ////////////////////////////////////////////////////////////
  // Pending register
  ////////////////////////////////////////////////////////////

  // Unimplemented lines never reach mip
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & `IRQ_LEGAL_MASK;
    end
  end

  assign csr.mip = mip_q;

  ////////////////////////////////////////////////////////////
  // Fixed priority select
  ////////////////////////////////////////////////////////////

  assign enabled   = mip_q & csr.mie_en;
  assign pending_o = |enabled;

  always_comb begin
    logic found_hi;
    found_hi = 1'b0;
    sel_id_o = '0;
    // Upward scan, highest set line wins
    for (int i = 16; i < `XLEN; i++) begin
      if (enabled[i]) begin
        sel_id_o = irq_pkg::irq_id_t'(i);
        found_hi = 1'b1;
      end
    end
    // Standard lines: external, software, timer
    if (!found_hi) begin
      if (enabled[11]) begin
        sel_id_o = irq_pkg::irq_id_t'(11);
      end else if (enabled[3]) begin
        sel_id_o = irq_pkg::irq_id_t'(3);
      end else if (enabled[7]) begin
        sel_id_o = irq_pkg::irq_id_t'(7);
      end
    end
  end

  // Selected line is both pending and enabled in the CSR block
  a_sel_valid : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    pending_o |-> (csr.mip[sel_id_o] && csr.mie_en[sel_id_o])
  );

endmodule

`default_nettype wire

//--- design/irq_trap_ctrl.sv
/* Take decision, registered acknowledge and WFI sleep flag.
   Wake from sleep needs only an enabled pending line and ignores MIE. */

`timescale 1ns/1ns
`default_nettype none

`include "irq_defs.svh"

module irq_trap_ctrl (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  input  wire logic              pending_i,
  input  wire irq_pkg::irq_id_t  sel_id_i,
  input  wire logic              wfi_i,
  irq_csr_if.trap                csr,
  output logic                   irq_ack_o,
  output irq_pkg::irq_id_t       irq_id_o,
  output logic                   core_sleep_o
);

  logic              take;
  logic              ack_q;
  irq_pkg::irq_id_t  id_q;
  logic              sleep_q;

  ////////////////////////////////////////////////////////////
  // Take and acknowledge
  ////////////////////////////////////////////////////////////

  // Enabled line pending and global enable set
  assign take = pending_i & csr.m_ie;

  // CSR block updates at the same edge
  assign csr.take    = take;
  assign csr.take_id = sel_id_i;

  // Ack pulse one edge after take
  // id only moves on a take and holds otherwise
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
      id_q  <= '0;
    end else begin
      ack_q <= take;
      if (take) begin
        id_q <= sel_id_i;
      end
    end
  end

  assign irq_ack_o = ack_q;
  assign irq_id_o  = id_q;

  ////////////////////////////////////////////////////////////
  // WFI sleep
  ////////////////////////////////////////////////////////////

  // Pending wins over a wfi in the same cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sleep_q <= 1'b0;
    end else if (pending_i) begin
      sleep_q <= 1'b0;
    end else if (wfi_i) begin
      sleep_q <= 1'b1;
    end
  end

  assign core_sleep_o = sleep_q;

  // Acks never come back to back since MIE clears after every take
  a_ack_single : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    irq_ack_o |=> !irq_ack_o
  );

  // Take needs MIE and trap entry in the CSR block drops it
  a_take_mie : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    csr.take |-> csr.m_ie ##1 !csr.m_ie
  );

endmodule

`default_nettype wire

//--- design/irq_unit.sv
/* Machine-mode interrupt unit top level, plain ports only.
   All core events are single-cycle strobes, nothing is ever refused. */

`timescale 1ns/1ns
`default_nettype none

`include "irq_defs.svh"

module irq_unit (
  // Clock and reset
  input  wire logic                    clk_i,
  input  wire logic                    rst_n_i,

  // Interrupt lines and acknowledge
  input  wire logic [`XLEN-1:0]        irq_i,
  output logic                         irq_ack_o,
  output irq_pkg::irq_id_t             irq_id_o,

  // CSR access from the core
  input  wire logic                    csr_we_i,
  input  wire logic [`CSR_ADDR_W-1:0]  csr_addr_i,
  input  wire logic [`XLEN-1:0]        csr_wdata_i,
  output logic      [`XLEN-1:0]        csr_rdata_o,

  // Core events and sleep status
  input  wire logic                    mret_i,
  input  wire logic                    wfi_i,
  output logic                         core_sleep_o
);

  // Arbiter to trap controller
  logic              pending;
  irq_pkg::irq_id_t  sel_id;

  irq_csr_if csr_if ();

  ////////////////////////////////////////////////////////////
  // CSRs
  ////////////////////////////////////////////////////////////

  irq_csr_regs csr_regs_i (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .csr_we_i    ( csr_we_i    ),
    .csr_addr_i  ( csr_addr_i  ),
    .csr_wdata_i ( csr_wdata_i ),
    .csr_rdata_o ( csr_rdata_o ),
    .mret_i      ( mret_i      ),
    .csr         ( csr_if.regs )
  );

  ////////////////////////////////////////////////////////////
  // Pending and priority
  ////////////////////////////////////////////////////////////

  irq_arbiter arbiter_i (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .irq_i     ( irq_i      ),
    .csr       ( csr_if.arb ),
    .pending_o ( pending    ),
    .sel_id_o  ( sel_id     )
  );

  // Take, ack and sleep
  irq_trap_ctrl trap_ctrl_i (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .pending_i    ( pending      ),
    .sel_id_i     ( sel_id       ),
    .wfi_i        ( wfi_i        ),
    .csr          ( csr_if.trap  ),
    .irq_ack_o    ( irq_ack_o    ),
    .irq_id_o     ( irq_id_o     ),
    .core_sleep_o ( core_sleep_o )
  );

endmodule

`default_nettype wire

//--- test/tb_irq_unit.sv
/* Random testbench for irq_unit against a cycle model of the CSR and trap rules.
   Inputs change on the falling edge, outputs are compared there too. */

`timescale 1ns/1ns
`default_nettype none

`include "irq_defs.svh"

module tb_irq_unit;

  localparam int NUM_CYCLES     = 1500;
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + 500;

  // DUT connections
  logic                    clk;
  logic                    rst_n;
  logic [`XLEN-1:0]        irq;
  logic                    csr_we;
  logic [`CSR_ADDR_W-1:0]  csr_addr;
  logic [`XLEN-1:0]        csr_wdata;
  logic [`XLEN-1:0]        csr_rdata;
  logic                    mret;
  logic                    wfi;
  logic                    irq_ack;
  logic [`IRQ_ID_W-1:0]    irq_id;
  logic                    core_sleep;

  // Model state, always the value after the coming rising edge
  logic                    m_mie;
  logic                    m_mpie;
  logic [`XLEN-1:0]        m_mie_en;
  logic [`XLEN-1:0]        m_mcause;
  logic [`XLEN-1:0]        m_mip;
  logic                    m_ack;
  logic [`IRQ_ID_W-1:0]    m_id;
  logic                    m_sleep;

  integer seed;
  int     errors;
  int     cycles;
  int     n_take;
  int     n_sleep;
  int     n_blocked;
  int     n_mret;

  irq_unit DUT (
    .clk_i        ( clk        ),
    .rst_n_i      ( rst_n      ),
    .irq_i        ( irq        ),
    .irq_ack_o    ( irq_ack    ),
    .irq_id_o     ( irq_id     ),
    .csr_we_i     ( csr_we     ),
    .csr_addr_i   ( csr_addr   ),
    .csr_wdata_i  ( csr_wdata  ),
    .csr_rdata_o  ( csr_rdata  ),
    .mret_i       ( mret       ),
    .wfi_i        ( wfi        ),
    .core_sleep_o ( core_sleep )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Hard stop if the main loop never ends
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////

  // Lines 31..16 highest first, then 11, 3, 7
  function automatic logic [`IRQ_ID_W-1:0] pick_line(input logic [`XLEN-1:0] en);
    logic [`IRQ_ID_W-1:0] id;
    logic                 found;
    id    = '0;
    found = 1'b0;
    for (int i = `XLEN - 1; i >= 16; i--) begin
      if (!found && en[i]) begin
        id    = i[`IRQ_ID_W-1:0];
        found = 1'b1;
      end
    end
    if (!found) begin
      if (en[11])     id = 5'd11;
      else if (en[3]) id = 5'd3;
      else if (en[7]) id = 5'd7;
    end
    return id;
  endfunction

  // Expected read data, unknown addresses give 0
  function automatic logic [`XLEN-1:0] model_read(input logic [`CSR_ADDR_W-1:0] addr);
    logic [`XLEN-1:0] v;
    v = '0;
    if (addr == irq_pkg::MSTATUS) begin
      v[`MSTATUS_MIE_BIT]  = m_mie;
      v[`MSTATUS_MPIE_BIT] = m_mpie;
    end else if (addr == irq_pkg::MIE) begin
      v = m_mie_en;
    end else if (addr == irq_pkg::MCAUSE) begin
      v = m_mcause;
    end else if (addr == irq_pkg::MIP) begin
      v = m_mip;
    end
    return v;
  endfunction

  task automatic reset_model();
    m_mie    = 1'b0;
    m_mpie   = 1'b0;
    m_mie_en = '0;
    m_mcause = '0;
    m_mip    = '0;
    m_ack    = 1'b0;
    m_id     = '0;
    m_sleep  = 1'b0;
  endtask

  // One rising edge with the inputs now on the DUT pins
  task automatic advance_model();
    logic [`XLEN-1:0]      enabled;
    logic                  pend;
    logic                  take;
    logic [`IRQ_ID_W-1:0]  sel;
    logic                  n_mie;
    logic                  n_mpie;
    logic [`XLEN-1:0]      n_en;
    logic [`XLEN-1:0]      n_cause;
    enabled = m_mip & m_mie_en;
    pend    = |enabled;
    sel     = pick_line(enabled);
    take    = pend & m_mie;
    n_mie   = m_mie;
    n_mpie  = m_mpie;
    n_en    = m_mie_en;
    n_cause = m_mcause;
    // Software write has the lowest priority
    if (csr_we) begin
      if (csr_addr == irq_pkg::MSTATUS) begin
        n_mie  = csr_wdata[`MSTATUS_MIE_BIT];
        n_mpie = csr_wdata[`MSTATUS_MPIE_BIT];
      end else if (csr_addr == irq_pkg::MIE) begin
        n_en = csr_wdata & `IRQ_LEGAL_MASK;
      end else if (csr_addr == irq_pkg::MCAUSE) begin
        n_cause = csr_wdata;
      end
    end
    if (mret) begin
      n_mie  = m_mpie;
      n_mpie = 1'b1;
      n_mret++;
    end
    // Trap entry beats both
    if (take) begin
      n_mpie  = m_mie;
      n_mie   = 1'b0;
      n_cause = (`XLEN'(1) << `MCAUSE_IRQ_BIT) | {{(`XLEN-`IRQ_ID_W){1'b0}}, sel};
      m_id    = sel;
      n_take++;
    end
    if (pend && !m_mie) n_blocked++;
    // Wake needs only an enabled pending line
    if (pend) begin
      m_sleep = 1'b0;
    end else if (wfi) begin
      m_sleep = 1'b1;
      n_sleep++;
    end
    m_ack    = take;
    m_mie    = n_mie;
    m_mpie   = n_mpie;
    m_mie_en = n_en;
    m_mcause = n_cause;
    m_mip    = irq & `IRQ_LEGAL_MASK;
  endtask

  //////////////////////////////////////////////////////////////
  // Stimulus and checks
  //////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%08h, expected 0x%08h at cycle %0d",
               name, got, exp, cycles);
    end
  endtask

  task automatic check_outputs();
    check_value("csr_rdata_o", csr_rdata, model_read(csr_addr));
    check_value("irq_ack_o", {31'd0, irq_ack}, {31'd0, m_ack});
    check_value("irq_id_o", {27'd0, irq_id}, {27'd0, m_id});
    check_value("core_sleep_o", {31'd0, core_sleep}, {31'd0, m_sleep});
  endtask

  task automatic drive_random();
    logic [31:0] r_irq;
    logic [31:0] r_ctl;
    logic [31:0] r_data;
    logic [31:0] r_wd;
    r_irq  = $random(seed);
    r_ctl  = $random(seed);
    r_data = $random(seed);
    r_wd   = $random(seed);
    // Lines change about once in 8 cycles, often back to idle
    if (r_irq[10:8] == 3'd0) begin
      case (r_irq[1:0])
        2'd0, 2'd1: irq = '0;
        2'd2:       irq = 32'd1 << r_irq[6:2];
        default:    irq = r_data;
      endcase
    end
    csr_we = (r_ctl[1:0] == 2'd0);
    case (r_ctl[4:2])
      3'd0, 3'd4: csr_addr = irq_pkg::MSTATUS;
      3'd1, 3'd5: csr_addr = irq_pkg::MIE;
      3'd2:       csr_addr = irq_pkg::MCAUSE;
      3'd3:       csr_addr = irq_pkg::MIP;
      3'd6:       csr_addr = 12'h305;
      default:    csr_addr = r_ctl[27:16];
    endcase
    csr_wdata = r_wd;
    mret      = (r_ctl[9:6] == 4'd0);
    wfi       = (r_ctl[13:10] == 4'd0);
  endtask

  initial begin
    seed      = 42822;
    errors    = 0;
    cycles    = 0;
    n_take    = 0;
    n_sleep   = 0;
    n_blocked = 0;
    n_mret    = 0;
    rst_n     = 1'b0;
    irq       = '0;
    csr_we    = 1'b0;
    csr_addr  = '0;
    csr_wdata = '0;
    mret      = 1'b0;
    wfi       = 1'b0;
    reset_model();

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Reset values first
    check_outputs();
    advance_model();

    for (int n = 0; n < NUM_CYCLES; n++) begin
      @(negedge clk);
      check_outputs();
      drive_random();
      advance_model();
    end

    // Stimulus must have reached each behavior
    if (n_take == 0) begin
      errors++;
      $display("Error: no interrupt was taken during the run");
    end
    if (n_sleep == 0) begin
      errors++;
      $display("Error: no wfi ever put the core to sleep");
    end
    if (n_blocked == 0) begin
      errors++;
      $display("Error: no pending interrupt was ever held off by a clear MIE");
    end
    if (n_mret == 0) begin
      errors++;
      $display("Error: no mret strobe was driven");
    end

    $display("Summary: %0d errors, %0d takes, %0d sleeps, %0d blocked, %0d mret",
             errors, n_take, n_sleep, n_blocked, n_mret);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+design
design/irq_pkg.sv
design/irq_csr_if.sv
design/irq_csr_regs.sv
design/irq_arbiter.sv
design/irq_trap_ctrl.sv
design/irq_unit.sv
test/tb_irq_unit.sv

//--- Makefile
# Verilator flow for the interrupt unit testbench
TOP := tb_irq_unit
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --assert -j 0 -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
